/* sources.f */
+incdir+rtl
rtl/tlb_pkg.sv
rtl/tlb_prio_encode.sv
rtl/tlb_entry_array.sv
rtl/tlb_lookup_stage.sv
rtl/tlb_translate_stage.sv
rtl/tlb_mmu_top.sv
dv/tlb_mmu_props.sv
dv/tlb_mmu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tlb_mmu_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tlb_mmu_tb.sv */
//****************************
// TLB MMU testbench
// Table-driven TLBWI, TLBP and translation checks
//****************************
module tlb_mmu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam tlb_pkg::tlb_op_e nop = tlb_pkg::TLB_NOP;
    localparam tlb_pkg::tlb_op_e wi  = tlb_pkg::TLB_WI;
    localparam tlb_pkg::tlb_op_e pr  = tlb_pkg::TLB_P;
    localparam int n_rows  = 15;
    localparam int timeout = 20;

    typedef struct packed {
        tlb_pkg::tlb_op_e op;
        logic [3:0]       idx;
        logic [31:0]      hi, lo0, lo1, va;
        logic             st;
        logic [1:0]       stall;
        logic [31:0]      exp_pa;
        logic [3:0]       exp_fl;       // cached, refill, invalid, modified
        logic [31:0]      exp_probe;
    } row_t;

    // EntryLo is pfn[25:6] c[5:3] d v g, EntryHi is vpn2[31:13] asid[7:0]
    row_t rows [n_rows] = '{
        '{wi, 4'd0, 32'h00020005, 32'h0000401e, 32'h00004056, '0, '0, '0, '0, '0, '0},
        '{wi, 4'd5, 32'h80000022, 32'h02af379f, 32'h0048d15f, '0, '0, '0, '0, '0, '0},
        '{wi, 4'd9, 32'h00040005, 32'h0000801a, 32'h0000805c, '0, '0, '0, '0, '0, '0},
        '{nop, '0, 32'h00000005, '0, '0, 32'h00020abc, 1'b0, 2'd0, 32'h00100abc, 4'b1000, '0},
        '{nop, '0, 32'h00000005, '0, '0, 32'h00021123, 1'b0, 2'd1, 32'h00101123, 4'b0000, '0},
        // Global pair, other ASID
        '{nop, '0, 32'h00000077, '0, '0, 32'h80000fff, 1'b0, 2'd2, 32'habcdefff, 4'b1000, '0},
        '{nop, '0, 32'h00000005, '0, '0, 32'h00060000, 1'b1, 2'd0, '0, 4'b0100, '0},
        '{nop, '0, 32'h00000006, '0, '0, 32'h00020abc, 1'b0, 2'd1, '0, 4'b0100, '0},
        '{nop, '0, 32'h00000005, '0, '0, 32'h00040010, 1'b1, 2'd2, 32'h00200010, 4'b1001, '0},
        '{nop, '0, 32'h00000005, '0, '0, 32'h00040010, 1'b0, 2'd0, 32'h00200010, 4'b1000, '0},
        '{nop, '0, 32'h00000005, '0, '0, 32'h00041010, 1'b0, 2'd1, 32'h00201010, 4'b1010, '0},
        // Duplicate of entry 9
        '{wi, 4'd12, 32'h00040005, 32'h0000801a, 32'h0000805c, '0, '0, '0, '0, '0, '0},
        '{pr, '0, 32'h00040005, '0, '0, '0, '0, '0, '0, '0, 32'h00000009},
        '{pr, '0, 32'h00080005, '0, '0, '0, '0, '0, '0, '0, 32'h80000000},
        '{pr, '0, 32'h80000001, '0, '0, '0, '0, '0, '0, '0, 32'h00000005}
    };

    logic             clk, rst;
    tlb_pkg::tlb_op_e i_tlb_op;
    logic [31:0]      i_index, i_entry_hi, i_entry_lo0, i_entry_lo1, i_vaddr;
    logic             i_en, i_store, i_stall;
    logic             o_rdy, o_cached, o_refill, o_invalid, o_modified, o_probe_wen;
    logic [31:0]      o_paddr, o_probe_index;
    int               errors = 0;
    int               checks = 0;
    integer           seed = 32'he30e;

    tlb_mmu_top tlb_mmu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_eq(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %h actual %h", what, exp, act);
        end
    endtask

    task automatic verify_result(input int r);
        expect_eq($sformatf("row %0d rdy/flags", r), {28'h0, 1'b1, rows[r].exp_fl[2:0]},
                  {28'h0, o_rdy, o_refill, o_invalid, o_modified});
        if (!rows[r].exp_fl[2]) begin    // No address on a refill
            expect_eq($sformatf("row %0d paddr", r), rows[r].exp_pa, o_paddr);
            expect_eq($sformatf("row %0d cached", r), {31'h0, rows[r].exp_fl[3]},
                      {31'h0, o_cached});
        end
    endtask

    task automatic write_entry(input int r);
        i_tlb_op    = wi;
        i_index     = {28'h0, rows[r].idx};
        i_entry_hi  = rows[r].hi;
        i_entry_lo0 = rows[r].lo0;
        i_entry_lo1 = rows[r].lo1;
        step();
        i_tlb_op = nop;
    endtask

    task automatic probe(input int r);
        i_tlb_op   = pr;
        i_entry_hi = rows[r].hi;
        step();
        i_tlb_op = nop;
        expect_eq($sformatf("row %0d probe strobe", r), 32'h1, {31'h0, o_probe_wen});
        expect_eq($sformatf("row %0d probe index", r), rows[r].exp_probe, o_probe_index);
        step();
        expect_eq($sformatf("row %0d probe strobe end", r), 32'h0, {31'h0, o_probe_wen});
    endtask

    task automatic translate(input int r, input int stalls);
        int n;
        n          = 0;
        i_entry_hi = rows[r].hi;
        i_vaddr    = rows[r].va;
        i_store    = rows[r].st;
        i_en       = 1'b1;
        while (!o_rdy && n < timeout) begin
            step();
            n++;
        end
        i_en = 1'b0;
        if (!o_rdy) begin
            errors++;
            $display("Row %0d timed out waiting for o_rdy", r);
        end else begin
            verify_result(r);
            for (int s = 0; s < stalls; s++) begin
                i_stall = 1'b1;
                step();
                verify_result(r);   // Held under stall
            end
            i_stall = 1'b0;
            step();
            expect_eq($sformatf("row %0d release", r), 32'h0,
                      {28'h0, o_rdy, o_refill, o_invalid, o_modified});
        end
    endtask

    initial begin
        rst         = 1'b1;
        i_tlb_op    = nop;
        i_index     = '0;
        i_entry_hi  = '0;
        i_entry_lo0 = '0;
        i_entry_lo1 = '0;
        i_vaddr     = '0;
        i_en        = 1'b0;
        i_store     = 1'b0;
        i_stall     = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        expect_eq("reset outputs", 32'h0,
                  {27'h0, o_rdy, o_refill, o_invalid, o_modified, o_probe_wen});
        for (int r = 0; r < n_rows; r++) begin
            case (rows[r].op)
                wi:      write_entry(r);
                pr:      probe(r);
                default: translate(r, int'(rows[r].stall));
            endcase
        end
        // Translations again with a random stall length
        for (int r = 0; r < n_rows; r++) begin
            if (rows[r].op == nop) begin
                translate(r, {$random(seed)} % 3);
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* dv/tlb_mmu_props.sv */
//****************************
// TLB MMU assertions
// Strobe, flag and ready rules
//****************************
module tlb_mmu_props (
    input logic clk,
    input logic rst,
    input logic i_stall,
    input logic o_rdy,
    input logic o_refill,
    input logic o_invalid,
    input logic o_modified,
    input logic o_probe_wen
);
    timeunit 1ns;
    timeprecision 1ps;

    a_probe_pulse: assert property (@(posedge clk) disable iff (rst)
        o_probe_wen |=> !o_probe_wen) else $error("probe strobe held past one cycle");

    a_flags_rdy: assert property (@(posedge clk) disable iff (rst)
        (o_refill || o_invalid || o_modified) |-> o_rdy) else $error("flag without ready");

    // Refill stands alone
    a_refill_only: assert property (@(posedge clk) disable iff (rst)
        o_refill |-> !(o_invalid || o_modified)) else $error("refill with other flags");

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (o_rdy && i_stall) |=> o_rdy) else $error("ready dropped under stall");

endmodule

bind tlb_mmu_top tlb_mmu_props tlb_mmu_props_inst (.*);

/* rtl/tlb_mmu_top.sv */
//****************************
// TLB MMU top
// Joint TLB with one data-side port
//****************************
`include "tlb_settings.svh"

module tlb_mmu_top (
    input  logic              clk,
    input  logic              rst,
    input  tlb_pkg::tlb_op_e  i_tlb_op,
    input  logic [31:0]       i_index,
    input  logic [31:0]       i_entry_hi,
    input  logic [31:0]       i_entry_lo0,
    input  logic [31:0]       i_entry_lo1,
    input  logic              i_en,
    input  logic [31:0]       i_vaddr,
    input  logic              i_store,
    input  logic              i_stall,
    output logic              o_rdy,
    output logic [31:0]       o_paddr,
    output logic              o_cached,
    output logic              o_refill,
    output logic              o_invalid,
    output logic              o_modified,
    output logic              o_probe_wen,
    output logic [31:0]       o_probe_index
);

    logic [31:0]          lk_vaddr;
    logic [`ASID_W-1:0]   lk_asid;
    tlb_pkg::tlb_idx_t    lk_hit_idx;
    logic                 lk_miss;
    tlb_pkg::tlb_idx_t    sel_idx;
    logic                 sel_miss;
    tlb_pkg::tlb_entry_t  sel_entry;
    logic                 lk_capture;
    logic                 lk_done;

    tlb_entry_array tlb_entry_array_inst (
        .clk           (clk),
        .rst           (rst),
        .i_tlb_op      (i_tlb_op),
        .i_index       (i_index),
        .i_entry_hi    (i_entry_hi),
        .i_entry_lo0   (i_entry_lo0),
        .i_entry_lo1   (i_entry_lo1),
        .i_lk_vaddr    (lk_vaddr),
        .i_lk_asid     (lk_asid),
        .i_sel_idx     (sel_idx),
        .o_lk_hit_idx  (lk_hit_idx),
        .o_lk_miss     (lk_miss),
        .o_sel_entry   (sel_entry),
        .o_probe_wen   (o_probe_wen),
        .o_probe_index (o_probe_index)
    );

    tlb_lookup_stage tlb_lookup_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .i_capture  (lk_capture),
        .i_vaddr    (i_vaddr),
        .i_entry_hi (i_entry_hi),
        .i_hit_idx  (lk_hit_idx),
        .i_miss     (lk_miss),
        .o_lk_vaddr (lk_vaddr),
        .o_lk_asid  (lk_asid),
        .o_sel_idx  (sel_idx),
        .o_sel_miss (sel_miss),
        .o_done     (lk_done)
    );

    tlb_translate_stage tlb_translate_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .i_en        (i_en),
        .i_store     (i_store),
        .i_stall     (i_stall),
        .i_tlb_op    (i_tlb_op),
        .i_lk_vaddr  (lk_vaddr),
        .i_sel_entry (sel_entry),
        .i_sel_miss  (sel_miss),
        .i_done      (lk_done),
        .o_capture   (lk_capture),
        .o_rdy       (o_rdy),
        .o_paddr     (o_paddr),
        .o_cached    (o_cached),
        .o_refill    (o_refill),
        .o_invalid   (o_invalid),
        .o_modified  (o_modified)
    );

endmodule

/* rtl/tlb_translate_stage.sv */
//****************************
// TLB translate stage
// Port FSM, address, flags, stall hold
//****************************
`include "tlb_settings.svh"

module tlb_translate_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_en,
    input  logic                 i_store,
    input  logic                 i_stall,
    input  tlb_pkg::tlb_op_e     i_tlb_op,
    input  logic [31:0]          i_lk_vaddr,
    input  tlb_pkg::tlb_entry_t  i_sel_entry,
    input  logic                 i_sel_miss,
    input  logic                 i_done,
    output logic                 o_capture,
    output logic                 o_rdy,
    output logic [31:0]          o_paddr,
    output logic                 o_cached,
    output logic                 o_refill,
    output logic                 o_invalid,
    output logic                 o_modified
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_XLATE,
        ST_READY
    } state_e;

    state_e              state;
    tlb_pkg::tlb_half_t  half;
    logic                finish;

    assign half      = i_lk_vaddr[`PAGE_OFS_W] ? i_sel_entry.odd : i_sel_entry.even;
    assign finish    = (state == ST_XLATE) && i_done;
    assign o_capture = (state == ST_IDLE) && i_en && !o_rdy &&
                       (i_tlb_op == tlb_pkg::TLB_NOP);  // CP0 ops take priority

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            o_rdy      <= 1'b0;
            o_refill   <= 1'b0;
            o_invalid  <= 1'b0;
            o_modified <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (o_capture) begin
                        state <= ST_XLATE;
                    end
                end
                ST_XLATE: begin
                    if (i_done) begin
                        state      <= ST_READY;
                        o_rdy      <= 1'b1;
                        o_refill   <= i_sel_miss;
                        o_invalid  <= !i_sel_miss && !half.v;
                        o_modified <= !i_sel_miss && i_store && !half.d;
                    end
                end
                ST_READY: begin
                    // Results held until the consumer releases
                    if (!i_stall) begin
                        state      <= ST_IDLE;
                        o_rdy      <= 1'b0;
                        o_refill   <= 1'b0;
                        o_invalid  <= 1'b0;
                        o_modified <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            o_paddr  <= {half.pfn, i_lk_vaddr[`PAGE_OFS_W-1:0]};
            o_cached <= (half.c == 3'(`CACHED_ATTR));
        end
    end

endmodule

/* rtl/tlb_lookup_stage.sv */
//****************************
// TLB lookup stage
// Request capture and hit index register
//****************************
`include "tlb_settings.svh"

module tlb_lookup_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_capture,
    input  logic [31:0]         i_vaddr,
    input  logic [31:0]         i_entry_hi,
    input  tlb_pkg::tlb_idx_t   i_hit_idx,
    input  logic                i_miss,
    output logic [31:0]         o_lk_vaddr,
    output logic [`ASID_W-1:0]  o_lk_asid,
    output tlb_pkg::tlb_idx_t   o_sel_idx,
    output logic                o_sel_miss,
    output logic                o_done
);

    logic pending;  // Compare running on captured request

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            pending <= i_capture;
            o_done  <= pending;
        end
    end

    always_ff @(posedge clk) begin
        if (i_capture) begin
            o_lk_vaddr <= i_vaddr;
            o_lk_asid  <= i_entry_hi[`ASID_W-1:0];
        end
    end

    // Hit result from the array's encoder
    always_ff @(posedge clk) begin
        if (pending) begin
            o_sel_idx  <= i_hit_idx;
            o_sel_miss <= i_miss;
        end
    end

endmodule

/* rtl/tlb_entry_array.sv */
//****************************
// TLB entry array
// Storage, TLBWI, compare, TLBP result
//****************************
`include "tlb_settings.svh"

module tlb_entry_array (
    input  logic                 clk,
    input  logic                 rst,
    input  tlb_pkg::tlb_op_e     i_tlb_op,
    input  logic [31:0]          i_index,
    input  logic [31:0]          i_entry_hi,
    input  logic [31:0]          i_entry_lo0,
    input  logic [31:0]          i_entry_lo1,
    input  logic [31:0]          i_lk_vaddr,
    input  logic [`ASID_W-1:0]   i_lk_asid,
    input  tlb_pkg::tlb_idx_t    i_sel_idx,
    output tlb_pkg::tlb_idx_t    o_lk_hit_idx,
    output logic                 o_lk_miss,
    output tlb_pkg::tlb_entry_t  o_sel_entry,
    output logic                 o_probe_wen,
    output logic [31:0]          o_probe_index
);

    tlb_pkg::tlb_entry_t          entries [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0]      lk_hit;
    logic [`TLB_ENTRIES-1:0]      p_hit;
    tlb_pkg::tlb_idx_t            p_idx;
    logic                         p_miss;
    tlb_pkg::tlb_idx_t            wr_idx;
    tlb_pkg::tlb_entry_t          wr_entry;

    assign wr_idx = i_index[`TLB_IDX_W-1:0];

    always_comb begin
        wr_entry.vpn2      = i_entry_hi[`VPN2_LSB +: `VPN2_W];
        wr_entry.asid      = i_entry_hi[`ASID_W-1:0];
        wr_entry.g         = i_entry_lo0[`LO_G_BIT] & i_entry_lo1[`LO_G_BIT];
        wr_entry.even.pfn  = i_entry_lo0[`LO_PFN_LSB +: `PFN_W];
        wr_entry.even.c    = i_entry_lo0[`LO_C_LSB +: 3];
        wr_entry.even.d    = i_entry_lo0[`LO_D_BIT];
        wr_entry.even.v    = i_entry_lo0[`LO_V_BIT];
        wr_entry.odd.pfn   = i_entry_lo1[`LO_PFN_LSB +: `PFN_W];
        wr_entry.odd.c     = i_entry_lo1[`LO_C_LSB +: 3];
        wr_entry.odd.d     = i_entry_lo1[`LO_D_BIT];
        wr_entry.odd.v     = i_entry_lo1[`LO_V_BIT];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (i_tlb_op == tlb_pkg::TLB_WI) begin
            entries[wr_idx] <= wr_entry;
        end
    end

    // Lookup uses the captured request, probe uses EntryHi directly
    for (genvar i = 0; i < `TLB_ENTRIES; i++) begin : g_cmp
        assign lk_hit[i] = (entries[i].vpn2 == i_lk_vaddr[`VPN2_LSB +: `VPN2_W]) &&
                           (entries[i].g || entries[i].asid == i_lk_asid);
        assign p_hit[i]  = (entries[i].vpn2 == i_entry_hi[`VPN2_LSB +: `VPN2_W]) &&
                           (entries[i].g || entries[i].asid == i_entry_hi[`ASID_W-1:0]);
    end

    tlb_prio_encode lk_enc_inst (
        .i_hit  (lk_hit),
        .o_idx  (o_lk_hit_idx),
        .o_miss (o_lk_miss)
    );

    tlb_prio_encode p_enc_inst (
        .i_hit  (p_hit),
        .o_idx  (p_idx),
        .o_miss (p_miss)
    );

    assign o_sel_entry = entries[i_sel_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_probe_wen <= 1'b0;
        end else begin
            o_probe_wen <= (i_tlb_op == tlb_pkg::TLB_P);   // One-cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        if (i_tlb_op == tlb_pkg::TLB_P) begin
            o_probe_index <= '0;
            if (p_miss) begin
                o_probe_index[`PROBE_MISS_BIT] <= 1'b1;
            end else begin
                o_probe_index[`TLB_IDX_W-1:0] <= p_idx;
            end
        end
    end

endmodule

/* rtl/tlb_prio_encode.sv */
//****************************
// TLB priority encoder
// Lowest set hit bit to an index
//****************************
`include "tlb_settings.svh"

module tlb_prio_encode (
    input  logic [`TLB_ENTRIES-1:0] i_hit,
    output tlb_pkg::tlb_idx_t       o_idx,
    output logic                    o_miss
);

    always_comb begin
        o_idx = '0;
        // Scan downward so the lowest hit wins
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (i_hit[i]) begin
                o_idx = tlb_pkg::tlb_idx_t'(i);
            end
        end
    end

    assign o_miss = ~|i_hit;

endmodule

/* rtl/tlb_pkg.sv */
//****************************
// TLB package
// Entry layout, op codes, index type
//****************************
`include "tlb_settings.svh"

package tlb_pkg;

    typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;

    typedef enum logic [1:0] {
        TLB_NOP = 2'd0,
        TLB_WI  = 2'd1,
        TLB_P   = 2'd2
    } tlb_op_e;

    // One 4 KB page of the pair
    typedef struct packed {
        logic [`PFN_W-1:0] pfn;
        logic [2:0]        c;
        logic              d;
        logic              v;
    } tlb_half_t;

    typedef struct packed {
        logic [`VPN2_W-1:0] vpn2;
        logic [`ASID_W-1:0] asid;
        logic               g;
        tlb_half_t          odd;
        tlb_half_t          even;
    } tlb_entry_t;

endpackage

/* rtl/tlb_settings.svh */
//****************************
// TLB settings
// Sizes and MIPS CP0 field positions
//****************************
`ifndef TLB_SETTINGS_SVH
`define TLB_SETTINGS_SVH

`define TLB_ENTRIES     16
`define TLB_IDX_W       4
`define ASID_W          8
`define VPN2_W          19
`define VPN2_LSB        13
`define PFN_W           20
`define PAGE_OFS_W      12

// EntryLo layout
`define LO_PFN_LSB      6
`define LO_C_LSB        3
`define LO_D_BIT        2
`define LO_V_BIT        1
`define LO_G_BIT        0

`define CACHED_ATTR     3   // Cacheable noncoherent
`define PROBE_MISS_BIT  31

`endif
